// ==== verilog/corr_defines.svh ====
`ifndef CORR_DEFINES_SVH
`define CORR_DEFINES_SVH

// ------------------------------------------------------------
// Array geometry
// ------------------------------------------------------------
`define NUM_ANT     4                    // Antennas in the array
`define TMUX_RATE   6                    // Pairs per sample, 4*3/2
`define SLOT_BITS   3                    // Slot pointer width

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define ACCUM_BITS  12                   // One sin or cos count
`define VIS_BITS    (2*`ACCUM_BITS)      // Packed {sin, cos}

// Readback bus
`define BUS_BITS    8
`define BANK_BITS   2                    // Visibility banks, 4 deep
`define CHUNKS      3                    // Bus bytes per visibility word

`endif

// ==== verilog/corr_pkg.sv ====
`include "corr_defines.svh"

package corr_pkg;

   typedef logic [`SLOT_BITS-1:0]  slot_t;    // Correlator slot
   typedef logic [`BANK_BITS-1:0]  bank_t;    // Visibility bank
   typedef logic [`ACCUM_BITS-1:0] accum_t;   // Match count
   typedef logic [`NUM_ANT-1:0]    ant_t;     // One bit per antenna
   typedef logic [`BUS_BITS-1:0]   bus_t;     // Bus byte

   // Sin in the upper half, cos in the lower half
   typedef struct packed {
      accum_t sin;
      accum_t cos;
   } vis_t;

   // Slot to antenna pair, (0,1),(0,2),(0,3),(1,2),(1,3),(2,3)
   // Slot 5 listed first, slot 0 last
   localparam logic [`TMUX_RATE-1:0][$clog2(`NUM_ANT)-1:0] pair_a =
      {2'd2, 2'd1, 2'd1, 2'd0, 2'd0, 2'd0};
   localparam logic [`TMUX_RATE-1:0][$clog2(`NUM_ANT)-1:0] pair_b =
      {2'd3, 2'd3, 2'd2, 2'd3, 2'd2, 2'd1};

endpackage

// ==== verilog/corr_cfg_regs.sv ====
`timescale 1ns/10ps
`include "corr_defines.svh"

module corr_cfg_regs (
   input  logic             clk_x,
   input  logic             sw_d,
   input  logic             cfg_we_i,
   input  logic [1:0]       cfg_adr_i,
   input  corr_pkg::bus_t   cfg_dat_i,
   output corr_pkg::bus_t   cfg_dat_o,
   output logic             enable_o,
   output corr_pkg::accum_t block_size_o
);
   import corr_pkg::*;

   localparam int HI_BITS = `ACCUM_BITS - `BUS_BITS;   // Bits in the upper byte

   logic   enable_q;
   accum_t bsize_q;   // Block size minus one

   // ------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         enable_q <= 1'b0;
         bsize_q  <= '0;   // One sample per block
      end else if (cfg_we_i) begin
         case (cfg_adr_i)
            2'd0: enable_q <= cfg_dat_i[0];
            2'd1: bsize_q[`BUS_BITS-1:0] <= cfg_dat_i;         // Low byte
            2'd2: bsize_q[`ACCUM_BITS-1:`BUS_BITS] <= cfg_dat_i[HI_BITS-1:0];
            default: ;
         endcase
      end
   end

   // Combinational readback
   always_comb begin
      case (cfg_adr_i)
         2'd0:    cfg_dat_o = {{(`BUS_BITS-1){1'b0}}, enable_q};
         2'd1:    cfg_dat_o = bsize_q[`BUS_BITS-1:0];
         2'd2:    cfg_dat_o = {{(`BUS_BITS-HI_BITS){1'b0}}, bsize_q[`ACCUM_BITS-1:`BUS_BITS]};
         default: cfg_dat_o = '0;
      endcase
   end

   // Block controller latches this at the start of each block
   assign enable_o     = enable_q;
   assign block_size_o = bsize_q;

   // Host must stay inside the three-register map
   a_cfg_adr: assert property (@(posedge clk_x) disable iff (sw_d)
      cfg_we_i |-> cfg_adr_i <= 2'd2);

endmodule

// ==== verilog/rmw_address_unit.sv ====
`timescale 1ns/10ps
`include "corr_defines.svh"

module rmw_address_unit (
   input  logic            clk_x,
   input  logic            sw_d,
   input  logic            ce_i,        // One pulse per slot
   output corr_pkg::slot_t rd_slot_o,
   output logic            rd_wrap_o,
   output corr_pkg::slot_t wr_slot_o,
   output logic            wr_wrap_o
);
   import corr_pkg::*;

   localparam slot_t LAST = slot_t'(`TMUX_RATE - 1);

   slot_t rd_q;
   slot_t wr_q;
   logic  ce_q;   // Write happens one enable behind the read

   assign rd_wrap_o = ce_i && (rd_q == LAST);   // Reading the last slot
   assign wr_wrap_o = ce_q && (wr_q == LAST);   // Writing the last slot

   // ------------------------------------------------------------
   // Slot pointers
   // ------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         rd_q <= '0;
         wr_q <= '0;
         ce_q <= 1'b0;
      end else begin
         ce_q <= ce_i;
         if (ce_i) begin
            rd_q <= rd_wrap_o ? '0 : rd_q + 1'b1;
            wr_q <= rd_q;   // Holds the last read slot once ce drops
         end
      end
   end

   assign rd_slot_o = rd_q;
   assign wr_slot_o = wr_q;

endmodule

// ==== verilog/quad_delay_stage.sv ====
`timescale 1ns/10ps
`include "corr_defines.svh"

module quad_delay_stage (
   input  logic           clk_x,
   input  logic           sw_d,
   input  logic           enable_i,
   input  logic           ant_stb_i,
   input  corr_pkg::ant_t ant_i,
   output corr_pkg::ant_t re_o,
   output corr_pkg::ant_t im_o,
   output logic           slot_valid_o,
   output logic           samp_done_o
);
   import corr_pkg::*;

   ant_t  smp_q;            // Raw sample at the strobe
   logic  start_q;          // Sample waiting to enter the slot loop
   ant_t  re_q, im_q;
   slot_t pend_q;           // Slots left for the current sample

   always_ff @(posedge clk_x) begin
      if (ant_stb_i && enable_i)
         smp_q <= ant_i;
   end

   // ------------------------------------------------------------
   // Quadrature stand-in and slot sequencer
   // ------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         start_q <= 1'b0;
         re_q    <= '0;
         im_q    <= '0;
         pend_q  <= '0;
      end else begin
         start_q <= ant_stb_i && enable_i;   // Strobes dropped while disabled
         if (start_q) begin
            re_q   <= smp_q;
            im_q   <= re_q;                  // Previous sample is the imaginary
            pend_q <= slot_t'(`TMUX_RATE);
         end else begin
            if (pend_q != '0)
               pend_q <= pend_q - 1'b1;     // Sample in flight still finishes
            if (!enable_i && pend_q == '0) begin
               re_q <= '0;                   // First sample after enable sees im = 0
               im_q <= '0;
            end
         end
      end
   end

   assign re_o         = re_q;
   assign im_o         = im_q;
   assign slot_valid_o = (pend_q != '0);
   assign samp_done_o  = (pend_q == slot_t'(1));   // Final slot of the sample

   // Strobe spacing keeps re and im stable over all slots of a sample
   a_stb_spacing: assert property (@(posedge clk_x) disable iff (sw_d)
      ant_stb_i && enable_i |=> !ant_stb_i [*(`TMUX_RATE-1)]);

endmodule

// ==== verilog/vis_correlator.sv ====
`timescale 1ns/10ps
`include "corr_defines.svh"

module vis_correlator (
   input  logic            clk_x,
   input  logic            sw_d,
   input  logic            en_i,        // Slot valid
   input  logic            clear_i,     // First pass of a new bank
   input  corr_pkg::ant_t  re_i,
   input  corr_pkg::ant_t  im_i,
   input  corr_pkg::slot_t rd_slot_i,
   input  corr_pkg::slot_t wr_slot_i,
   output logic            vis_we_o,
   output corr_pkg::slot_t vis_slot_o,
   output corr_pkg::vis_t  vis_word_o
);
   import corr_pkg::*;

   vis_t acc_mem [`TMUX_RATE];   // One {sin, cos} per pair

   logic [$clog2(`NUM_ANT)-1:0] ant_a, ant_b;
   logic cos_hit, sin_hit;
   logic cos_hit_q, sin_hit_q;
   logic v_q;
   vis_t acc_q;
   vis_t base;
   vis_t sum;

   // ------------------------------------------------------------
   // Stage 1, pair select and accumulator read
   // ------------------------------------------------------------
   assign ant_a   = pair_a[rd_slot_i];
   assign ant_b   = pair_b[rd_slot_i];
   assign cos_hit = (re_i[ant_a] == re_i[ant_b]);   // Real against real
   assign sin_hit = (re_i[ant_a] == im_i[ant_b]);   // Real against delayed

   always_ff @(posedge clk_x) begin
      acc_q     <= acc_mem[rd_slot_i];   // Synchronous read
      cos_hit_q <= cos_hit;
      sin_hit_q <= sin_hit;
   end

   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d)
         v_q <= 1'b0;
      else
         v_q <= en_i;
   end

   // ------------------------------------------------------------
   // Stage 2, add and write back
   // ------------------------------------------------------------
   assign base    = clear_i ? '0 : acc_q;   // Fresh bank starts from zero
   assign sum.sin = base.sin + accum_t'(sin_hit_q);
   assign sum.cos = base.cos + accum_t'(cos_hit_q);

   always_ff @(posedge clk_x) begin
      if (v_q)
         acc_mem[wr_slot_i] <= sum;
   end

   // Same update goes to the visibility bank
   assign vis_we_o   = v_q;
   assign vis_slot_o = wr_slot_i;
   assign vis_word_o = sum;

   // Write pointer must trail the read pointer by exactly one slot
   a_rmw_align: assert property (@(posedge clk_x) disable iff (sw_d)
      v_q |-> wr_slot_i == $past(rd_slot_i));

endmodule

// ==== verilog/bank_switch_ctrl.sv ====
`timescale 1ns/10ps

module bank_switch_ctrl (
   input  logic             clk_x,
   input  logic             sw_d,
   input  logic             samp_done_i,
   input  logic             wr_wrap_i,
   input  corr_pkg::accum_t block_size_i,
   output logic             clear_o,
   output corr_pkg::bank_t  wr_bank_o,
   output corr_pkg::bank_t  rd_bank_o,
   output logic             newblock_o
);
   import corr_pkg::*;

   accum_t count_q;       // Samples done in this block
   accum_t limit_q;       // Block size captured at block start
   accum_t limit;
   logic   last_samp;
   logic   swap_pend_q;
   logic   swap;
   logic   swap_q;
   bank_t  wr_bank_q, rd_bank_q;
   logic   clear_q;

   // New size only counts from the first sample of a block
   assign limit     = (count_q == '0) ? block_size_i : limit_q;
   assign last_samp = samp_done_i && (count_q == limit);
   assign swap      = wr_wrap_i && swap_pend_q;   // Last word of the block written

   // ------------------------------------------------------------
   // Sample counter
   // ------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         count_q     <= '0;
         limit_q     <= '0;
         swap_pend_q <= 1'b0;
      end else begin
         if (samp_done_i) begin
            if (count_q == '0)
               limit_q <= block_size_i;
            count_q <= last_samp ? '0 : count_q + 1'b1;
         end
         if (last_samp)
            swap_pend_q <= 1'b1;     // Swap at the next write wrap
         else if (swap)
            swap_pend_q <= 1'b0;
      end
   end

   // ------------------------------------------------------------
   // Bank pointers and clear
   // ------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         wr_bank_q  <= '0;
         rd_bank_q  <= '0;
         clear_q    <= 1'b1;   // First pass after reset starts from zero
         swap_q     <= 1'b0;
         newblock_o <= 1'b0;
      end else begin
         if (swap) begin
            wr_bank_q <= wr_bank_q + 1'b1;
            clear_q   <= 1'b1;
         end else if (wr_wrap_i && clear_q) begin
            clear_q   <= 1'b0;               // First pass over, accumulate now
         end
         swap_q     <= swap;
         newblock_o <= swap_q;               // Publish once the last word settled
         if (swap_q)
            rd_bank_q <= bank_t'(wr_bank_q - 1'b1);   // Bank just finished
      end
   end

   assign clear_o   = clear_q;
   assign wr_bank_o = wr_bank_q;
   assign rd_bank_o = rd_bank_q;

   // A block may not finish before the previous swap went through
   a_no_overrun: assert property (@(posedge clk_x) disable iff (sw_d)
      last_samp |-> !swap_pend_q);

endmodule

// ==== verilog/vis_readback.sv ====
`timescale 1ns/10ps
`include "corr_defines.svh"

module vis_readback (
   input  logic            clk_x,
   input  logic            sw_d,
   input  logic            vis_we_i,
   input  corr_pkg::bank_t wr_bank_i,
   input  corr_pkg::slot_t vis_slot_i,
   input  corr_pkg::vis_t  vis_word_i,
   input  corr_pkg::bank_t rd_bank_i,
   input  logic            newblock_i,
   input  logic            bus_cyc_i,
   input  logic            bus_stb_i,
   output logic            bus_ack_o,
   output corr_pkg::bus_t  bus_dat_o
);
   import corr_pkg::*;

   localparam int CBITS = $clog2(`CHUNKS);
   localparam slot_t LAST_SLOT = slot_t'(`TMUX_RATE - 1);
   localparam logic [CBITS-1:0] LAST_CHUNK = CBITS'(`CHUNKS - 1);

   vis_t vis_mem [1 << (`BANK_BITS + `SLOT_BITS)];   // Bank-major, slot-minor

   slot_t                slot_q, cur_slot;
   logic [CBITS-1:0]     chunk_q, cur_chunk;
   logic [`VIS_BITS-1:0] rd_word;
   bus_t                 rd_byte;
   logic                 req;

   always_ff @(posedge clk_x) begin
      if (vis_we_i)
         vis_mem[{wr_bank_i, vis_slot_i}] <= vis_word_i;
   end

   // ------------------------------------------------------------
   // Byte reader
   // ------------------------------------------------------------
   assign req       = bus_cyc_i && bus_stb_i;
   assign cur_slot  = newblock_i ? '0 : slot_q;    // Pointer is at byte 0 on newblock
   assign cur_chunk = newblock_i ? '0 : chunk_q;
   assign rd_word   = vis_mem[{rd_bank_i, cur_slot}];
   assign rd_byte   = rd_word[cur_chunk*`BUS_BITS +: `BUS_BITS];   // Low byte first

   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         bus_ack_o <= 1'b0;
         slot_q    <= '0;
         chunk_q   <= '0;
      end else begin
         bus_ack_o <= req;                          // Always acked next cycle
         if (req) begin
            if (cur_chunk == LAST_CHUNK) begin
               chunk_q <= '0;
               slot_q  <= (cur_slot == LAST_SLOT) ? '0 : cur_slot + 1'b1;
            end else begin
               chunk_q <= cur_chunk + 1'b1;
               slot_q  <= cur_slot;
            end
         end else if (newblock_i) begin
            chunk_q <= '0;
            slot_q  <= '0;
         end
      end
   end

   always_ff @(posedge clk_x) begin
      if (req)
         bus_dat_o <= rd_byte;
   end

endmodule

// ==== verilog/vis_dsp_top.sv ====
`timescale 1ns/10ps

module vis_dsp_top (
   input  logic             clk_x,
   input  logic             sw_d,
   input  logic             cfg_we_i,
   input  logic [1:0]       cfg_adr_i,
   input  corr_pkg::bus_t   cfg_dat_i,
   output corr_pkg::bus_t   cfg_dat_o,
   input  logic             ant_stb_i,
   input  corr_pkg::ant_t   ant_i,
   input  logic             bus_cyc_i,
   input  logic             bus_stb_i,
   output logic             bus_ack_o,
   output corr_pkg::bus_t   bus_dat_o,
   output logic             newblock_o
);
   import corr_pkg::*;

   logic   enable, slot_valid, samp_done;
   accum_t block_size;
   ant_t   re, im;
   slot_t  rd_slot, wr_slot, vis_slot;
   logic   wr_wrap, clear, vis_we;
   bank_t  wr_bank, rd_bank;
   vis_t   vis_word;

   // ------------------------------------------------------------
   // Control side
   // ------------------------------------------------------------
   corr_cfg_regs u_cfg (
      .clk_x(clk_x), .sw_d(sw_d), .cfg_we_i(cfg_we_i), .cfg_adr_i(cfg_adr_i),
      .cfg_dat_i(cfg_dat_i), .cfg_dat_o(cfg_dat_o),
      .enable_o(enable), .block_size_o(block_size));

   bank_switch_ctrl u_bank (
      .clk_x(clk_x), .sw_d(sw_d), .samp_done_i(samp_done), .wr_wrap_i(wr_wrap),
      .block_size_i(block_size), .clear_o(clear), .wr_bank_o(wr_bank),
      .rd_bank_o(rd_bank), .newblock_o(newblock_o));

   rmw_address_unit u_rmw (
      .clk_x(clk_x), .sw_d(sw_d), .ce_i(slot_valid),
      .rd_slot_o(rd_slot), .rd_wrap_o(),   // Read wrap only steers the pointer
      .wr_slot_o(wr_slot), .wr_wrap_o(wr_wrap));

   // ------------------------------------------------------------
   // Datapath
   // ------------------------------------------------------------
   quad_delay_stage u_quad (
      .clk_x(clk_x), .sw_d(sw_d), .enable_i(enable), .ant_stb_i(ant_stb_i),
      .ant_i(ant_i), .re_o(re), .im_o(im),
      .slot_valid_o(slot_valid), .samp_done_o(samp_done));

   vis_correlator u_corr (
      .clk_x(clk_x), .sw_d(sw_d), .en_i(slot_valid), .clear_i(clear),
      .re_i(re), .im_i(im), .rd_slot_i(rd_slot), .wr_slot_i(wr_slot),
      .vis_we_o(vis_we), .vis_slot_o(vis_slot), .vis_word_o(vis_word));

   vis_readback u_rdbk (
      .clk_x(clk_x), .sw_d(sw_d), .vis_we_i(vis_we), .wr_bank_i(wr_bank),
      .vis_slot_i(vis_slot), .vis_word_i(vis_word), .rd_bank_i(rd_bank),
      .newblock_i(newblock_o), .bus_cyc_i(bus_cyc_i), .bus_stb_i(bus_stb_i),
      .bus_ack_o(bus_ack_o), .bus_dat_o(bus_dat_o));

endmodule

// ==== tests/tb_vis_dsp.sv ====
`timescale 1ns/10ps
`include "corr_defines.svh"

module tb_vis_dsp;
   import corr_pkg::*;

   localparam int NB_TIMEOUT   = 400;   // Cycles to wait for newblock_o
   localparam int ACK_TIMEOUT  = 20;    // Cycles to wait for bus_ack_o
   localparam int QUIET_CYCLES = 40;    // Window with enable low

   logic   clk_x, sw_d;
   logic   cfg_we_i;
   logic [1:0] cfg_adr_i;
   bus_t   cfg_dat_i, cfg_dat_o;
   logic   ant_stb_i;
   ant_t   ant_i;
   logic   bus_cyc_i, bus_stb_i, bus_ack_o;
   bus_t   bus_dat_o;
   logic   newblock_o;

   logic [`VIS_BITS-1:0] exp_q[$];   // Expected words, slot order, block after block
   ant_t        prev_smp;            // Last sample of the previous block
   int          n_checks, n_errors, n_other;
   int unsigned seed_val;

   vis_dsp_top i_vis_dsp_top (
      .clk_x(clk_x), .sw_d(sw_d), .cfg_we_i(cfg_we_i), .cfg_adr_i(cfg_adr_i),
      .cfg_dat_i(cfg_dat_i), .cfg_dat_o(cfg_dat_o), .ant_stb_i(ant_stb_i),
      .ant_i(ant_i), .bus_cyc_i(bus_cyc_i), .bus_stb_i(bus_stb_i),
      .bus_ack_o(bus_ack_o), .bus_dat_o(bus_dat_o), .newblock_o(newblock_o));

   always #50 clk_x = ~clk_x;   // 100 ns period

   // ------------------------------------------------------------
   // Reference model and compare
   // ------------------------------------------------------------
   // {sin, cos} of one slot over one block
   function automatic logic [`VIS_BITS-1:0] ref_word(input int slot, input ant_t smp[$],
                                                     input ant_t prev);
      int a, b, k, i;
      logic [1:0] pa, pb;
      ant_t re, im;
      logic [`ACCUM_BITS-1:0] sin_n, cos_n;
      k     = 0;
      pa    = '0;
      pb    = '0;
      sin_n = '0;
      cos_n = '0;
      for (a = 0; a < `NUM_ANT; a++) begin      // Pairs in (0,1),(0,2).. order
         for (b = a + 1; b < `NUM_ANT; b++) begin
            if (k == slot) begin
               pa = 2'(a);
               pb = 2'(b);
            end
            k++;
         end
      end
      for (i = 0; i < smp.size(); i++) begin
         re = smp[i];
         im = (i == 0) ? prev : smp[i-1];       // One-sample delay
         if (re[pa] == re[pb])
            cos_n++;
         if (re[pa] == im[pb])
            sin_n++;
      end
      return {sin_n, cos_n};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
         n_errors++;
      end
   endtask

   // ------------------------------------------------------------
   // Bus and config access
   // ------------------------------------------------------------
   task automatic write_cfg(input logic [1:0] adr, input bus_t dat);
      @(posedge clk_x);
      #5;
      cfg_we_i  = 1'b1;
      cfg_adr_i = adr;
      cfg_dat_i = dat;
      @(posedge clk_x);
      #5;
      cfg_we_i  = 1'b0;
   endtask

   task automatic read_cfg(input logic [1:0] adr, input bus_t exp);
      @(posedge clk_x);
      #5;
      cfg_adr_i = adr;
      @(negedge clk_x);                          // Combinational, settled mid-cycle
      check_value("cfg_dat_o", 32'(cfg_dat_o), 32'(exp));
   endtask

   task automatic read_byte(output bus_t dat);
      int t;
      @(posedge clk_x);
      #5;
      bus_cyc_i = 1'b1;
      bus_stb_i = 1'b1;
      @(posedge clk_x);
      #5;
      bus_cyc_i = 1'b0;                          // One request at a time
      bus_stb_i = 1'b0;
      t = 0;
      @(negedge clk_x);
      while (!bus_ack_o && t < ACK_TIMEOUT) begin
         @(negedge clk_x);
         t++;
      end
      if (!bus_ack_o) begin
         $display("Timeout: bus_ack_o stayed low after a read request");
         n_other++;
      end
      dat = bus_dat_o;
   endtask

   task automatic wait_newblock(output bit seen);
      int t;
      seen = 1'b0;
      t    = 0;
      while (!seen && t < NB_TIMEOUT) begin
         @(negedge clk_x);
         seen = newblock_o;
         t++;
      end
      if (!seen) begin
         $display("Timeout: newblock_o did not pulse within %0d cycles", NB_TIMEOUT);
         n_other++;
      end
   endtask

   // Wait for the block, then read 18 bytes, low byte first
   task automatic check_block();
      logic [`VIS_BITS-1:0] w[`TMUX_RATE];
      bus_t got;
      bit   seen;
      int   s, c;
      for (s = 0; s < `TMUX_RATE; s++)
         w[s] = exp_q.pop_front();
      wait_newblock(seen);
      if (!seen)
         return;
      for (s = 0; s < `TMUX_RATE; s++) begin
         for (c = 0; c < `CHUNKS; c++) begin
            read_byte(got);
            check_value("bus_dat_o", 32'(got), 32'(8'(w[s] >> (8 * c))));
         end
      end
   endtask

   // ------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------
   task automatic send_strobe(output ant_t smp);
      smp = ant_t'($urandom_range(15, 0));
      @(posedge clk_x);
      #5;
      ant_stb_i = 1'b1;
      ant_i     = smp;
      @(posedge clk_x);
      #5;
      ant_stb_i = 1'b0;
      repeat (6) @(posedge clk_x);               // 8 cycles per sample
   endtask

   // chg_at < 0 leaves the block size alone
   task automatic send_block(input int n, input int chg_at,
                             input logic [`ACCUM_BITS-1:0] new_size);
      ant_t smp[$];
      ant_t a;
      int   i;
      for (i = 0; i < n; i++) begin
         send_strobe(a);
         smp.push_back(a);
         if (i == chg_at) begin                  // Mid-block size change
            write_cfg(2'd1, new_size[7:0]);
            write_cfg(2'd2, 8'(new_size[11:8]));
            read_cfg(2'd1, new_size[7:0]);
            read_cfg(2'd2, 8'(new_size[11:8]));
         end
      end
      for (i = 0; i < `TMUX_RATE; i++)
         exp_q.push_back(ref_word(i, smp, prev_smp));
      prev_smp = smp[n-1];
   endtask

   initial begin
      ant_t dropped;
      int   a;
      clk_x = 1'b0;
      sw_d  = 1'b1;
      cfg_we_i  = 1'b0;
      cfg_adr_i = '0;
      cfg_dat_i = '0;
      ant_stb_i = 1'b0;
      ant_i     = '0;
      bus_cyc_i = 1'b0;
      bus_stb_i = 1'b0;
      n_checks  = 0;
      n_errors  = 0;
      n_other   = 0;
      prev_smp  = '0;                            // im starts at zero on enable
      seed_val  = $urandom(88348);
      repeat (10) @(posedge clk_x);
      #5;
      sw_d = 1'b0;

      // Reset state at every address
      for (a = 0; a < 4; a++) begin
         read_cfg(2'(a), 8'h00);
         check_value("newblock_o", 32'(newblock_o), 32'h0);
         check_value("bus_ack_o", 32'(bus_ack_o), 32'h0);
      end
      write_cfg(2'd2, 8'hff);                    // Upper byte holds 4 bits
      read_cfg(2'd2, 8'h0f);
      write_cfg(2'd2, 8'h00);
      write_cfg(2'd1, 8'h0f);                    // 16 samples per block
      read_cfg(2'd1, 8'h0f);
      write_cfg(2'd0, 8'h01);
      read_cfg(2'd0, 8'h01);

      // Each block is read while the next one accumulates
      send_block(16, -1, '0);
      fork
         send_block(16, 2, 12'd7);               // New size from the next block
         check_block();
      join
      fork
         send_block(8, -1, '0);
         check_block();
      join
      fork
         send_block(8, -1, '0);
         check_block();
      join
      check_block();

      // Strobes are dropped while disabled
      write_cfg(2'd0, 8'h00);
      read_cfg(2'd0, 8'h00);
      write_cfg(2'd1, 8'h00);                    // Any counted strobe would end a block
      fork
         repeat (3) send_strobe(dropped);
         repeat (QUIET_CYCLES) begin
            @(negedge clk_x);
            check_value("newblock_o", 32'(newblock_o), 32'h0);
         end
      join
      write_cfg(2'd1, 8'h07);                    // Back to 8 samples per block
      write_cfg(2'd0, 8'h01);
      prev_smp = '0;
      send_block(8, -1, '0);
      check_block();

      $display("Checks: %0d, value errors: %0d, other failures: %0d",
               n_checks, n_errors, n_other);
      if (n_errors == 0 && n_other == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/corr_pkg.sv
verilog/corr_cfg_regs.sv
verilog/rmw_address_unit.sv
verilog/quad_delay_stage.sv
verilog/vis_correlator.sv
verilog/bank_switch_ctrl.sv
verilog/vis_readback.sv
verilog/vis_dsp_top.sv
tests/tb_vis_dsp.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_vis_dsp -Mdir obj_dir -o tb_vis_dsp
	obj_dir/tb_vis_dsp | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
